/* cube_macros.svh */
// shared constants for the cube design: 480p timing, framebuffer geometry and register map
// include wherever a size, a timing or a register address is needed
`ifndef CUBE_MACROS_SVH
`define CUBE_MACROS_SVH

`define H_ACTIVE 640
`define H_FP 16
`define H_SYNC 96
`define H_BP 48

`define V_ACTIVE 480
`define V_FP 10
`define V_SYNC 2
`define V_BP 33

`define FB_WIDTH 160
`define FB_HEIGHT 90
`define FB_SCALE 4

`define LB_TOP 60
`define LB_BOTTOM 420

`define CORDW 16
`define CIDXW 2
`define CHANW 4
`define EDGE_CNT 9

`define REG_CTRL 3'd0
`define REG_PAL0 3'd1
`define REG_PAL1 3'd2
`define REG_PAL2 3'd3
`define REG_PAL3 3'd4

`endif

/* video_pkg.sv */
// display-side types: screen coordinates, the sync bundle and 12-bit colours
// used by the timing generator, the framebuffer and the top level
`include "cube_macros.svh"

package video_pkg;

    // signed so the letterbox offset can go below zero
    typedef logic signed [`CORDW-1:0] coord_t;

    typedef struct packed {
        logic hsync;  // active low
        logic vsync;  // active low
        logic de;
    } sync_t;

    typedef struct packed {
        logic [`CHANW-1:0] red;
        logic [`CHANW-1:0] green;
        logic [`CHANW-1:0] blue;
    } rgb_t;

endpackage

/* draw_pkg.sv */
// drawing-side types: line endpoints and the host register word
// the register address decides which view of the word is decoded
`include "cube_macros.svh"

package draw_pkg;

    typedef struct packed {
        video_pkg::coord_t x0;
        video_pkg::coord_t y0;
        video_pkg::coord_t x1;
        video_pkg::coord_t y1;
    } line_t;

    typedef struct packed {
        logic              enable;      // start a run
        logic [`CIDXW-1:0] cidx;        // edge colour
        logic [7:0]        frame_wait;  // frames before drawing
        logic [4:0]        rsvd;
    } ctrl_word_t;

    typedef struct packed {
        logic [3:0]        rsvd;
        video_pkg::rgb_t   rgb;
    } pal_word_t;

    typedef union packed {
        ctrl_word_t ctrl_view;  // REG_CTRL
        pal_word_t  pal_view;   // REG_PAL0..REG_PAL3
    } reg_word_t;

endpackage

/* display_timings.sv */
// 640x480 timing generator with the counter origin at the first active pixel
// sync and de are decoded combinationally, so they line up with sx and sy
`timescale 1ns/1ps
`include "cube_macros.svh"

module display_timings (
    input  logic               clk_pix,
    input  logic               arst_n,
    output video_pkg::coord_t  sx,
    output video_pkg::coord_t  sy,
    output video_pkg::sync_t   sync,
    output logic               frame,
    output logic               line
);
    import video_pkg::*;

    localparam int H_SYNC_STA = `H_ACTIVE + `H_FP;
    localparam int H_SYNC_END = H_SYNC_STA + `H_SYNC;
    localparam int H_TOTAL    = H_SYNC_END + `H_BP;
    localparam int V_SYNC_STA = `V_ACTIVE + `V_FP;
    localparam int V_SYNC_END = V_SYNC_STA + `V_SYNC;
    localparam int V_TOTAL    = V_SYNC_END + `V_BP;
    localparam coord_t ONE    = 1;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_TOTAL - 1) begin  // end of line
            sx <= '0;
            sy <= (sy == V_TOTAL - 1) ? '0 : sy + ONE;
        end else begin
            sx <= sx + ONE;
        end
    end

    always_comb begin
        sync.hsync = !(sx >= H_SYNC_STA && sx < H_SYNC_END);
        sync.vsync = !(sy >= V_SYNC_STA && sy < V_SYNC_END);
        sync.de    = (sx < `H_ACTIVE) && (sy < `V_ACTIVE);
        line       = (sx == 0);
        frame      = line && (sy == 0);  // once per frame at the origin
    end

endmodule

/* draw_line.sv */
// Bresenham line rasteriser, one pixel per cycle while oe is high
// endpoints are latched on start and the line is always drawn top-down
`timescale 1ns/1ps

module draw_line (
    input  logic               clk_pix,
    input  logic               arst_n,
    input  logic               start,
    input  logic               oe,
    input  draw_pkg::line_t    coords,
    output video_pkg::coord_t  x,
    output video_pkg::coord_t  y,
    output logic               drawing,
    output logic               done
);
    import video_pkg::*;

    localparam coord_t ONE = 1;

    typedef enum logic {IDLE, DRAW} state_t;
    state_t state;

    logic   swap, right, movx, movy;
    coord_t xa, ya, xb, yb;   // endpoints ordered top-down
    coord_t dx0, dy0;
    coord_t x_end, y_end;
    coord_t dx, dy, err, err2;

    always_comb begin
        swap = coords.y0 > coords.y1;
        xa   = swap ? coords.x1 : coords.x0;
        ya   = swap ? coords.y1 : coords.y0;
        xb   = swap ? coords.x0 : coords.x1;
        yb   = swap ? coords.y0 : coords.y1;
        dx0  = (xa < xb) ? xb - xa : xa - xb;
        dy0  = ya - yb;  // never positive
        err2 = err <<< 1;
        movx = err2 >= dy;
        movy = err2 <= dx;
    end

    assign drawing = (state == DRAW) && oe;  // low oe stalls the walk

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: if (start) state <= DRAW;
                DRAW: begin
                    if (oe && x == x_end && y == y_end) begin  // last pixel out
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_pix) begin
        if (state == IDLE && start) begin
            x     <= xa;
            y     <= ya;
            x_end <= xb;
            y_end <= yb;
            right <= xa < xb;
            dx    <= dx0;
            dy    <= dy0;
            err   <= dx0 + dy0;
        end else if (drawing) begin
            if (movx) x <= right ? x + ONE : x - ONE;
            if (movy) y <= y + ONE;
            err <= err + (movx ? dy : '0) + (movy ? dx : '0);
        end
    end

endmodule

/* framebuffer.sv */
// 160x90 store of 2-bit colour indices, shown scaled by 4 inside a 16:9 letterbox
// write port from the line drawer, read side follows the display counters
`timescale 1ns/1ps
`include "cube_macros.svh"

module framebuffer (
    input  logic                    clk_pix,
    input  logic                    arst_n,
    input  logic                    we,
    input  video_pkg::coord_t       wx,
    input  video_pkg::coord_t       wy,
    input  logic [`CIDXW-1:0]       wcidx,
    input  video_pkg::coord_t       sx,
    input  video_pkg::coord_t       sy,
    input  video_pkg::rgb_t [3:0]   palette,
    output video_pkg::rgb_t         rgb
);
    import video_pkg::*;

    localparam int DEPTH = `FB_WIDTH * `FB_HEIGHT;
    localparam int ADDRW = $clog2(DEPTH);

    logic [`CIDXW-1:0] mem [DEPTH];

    logic             in_bounds, in_lb;
    logic [ADDRW-1:0] waddr, raddr;
    coord_t           rx, ry;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;  // blank picture, background colour
        end
    end

    always_comb begin
        in_bounds = wx >= 0 && wx < `FB_WIDTH && wy >= 0 && wy < `FB_HEIGHT;
        waddr     = ADDRW'(wy * `FB_WIDTH + wx);
        in_lb     = sx >= 0 && sx < `H_ACTIVE && sy >= `LB_TOP && sy < `LB_BOTTOM;
        rx        = coord_t'(sx / `FB_SCALE);
        ry        = coord_t'((sy - `LB_TOP) / `FB_SCALE);
        raddr     = ADDRW'(ry * `FB_WIDTH + rx);
    end

    always_ff @(posedge clk_pix) begin
        if (we && in_bounds) mem[waddr] <= wcidx;  // clipped writes are dropped
    end

    // palette lookup registered, rgb trails sx/sy by one cycle
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            rgb <= '0;
        end else begin
            rgb <= in_lb ? palette[mem[raddr]] : '0;  // black bars and blanking
        end
    end

endmodule

/* cube_regs.sv */
// host register block: run control word at REG_CTRL, four palette entries after it
// a write lands on the clock edge where reg_we is high
`timescale 1ns/1ps
`include "cube_macros.svh"

module cube_regs (
    input  logic                   clk_pix,
    input  logic                   arst_n,
    input  logic                   reg_we,
    input  logic [2:0]             reg_addr,
    input  draw_pkg::reg_word_t    reg_wdata,
    output logic                   enable,
    output logic [`CIDXW-1:0]      cidx,
    output logic [7:0]             frame_wait,
    output video_pkg::rgb_t [3:0]  palette
);

    logic [1:0] pal_sel;

    assign pal_sel = 2'(reg_addr - `REG_PAL0);  // palette entry for this address

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            enable     <= 1'b0;
            cidx       <= '0;
            frame_wait <= '0;
            palette[0] <= 12'h000;  // black
            palette[1] <= 12'hf00;  // red
            palette[2] <= 12'h0f0;  // green
            palette[3] <= 12'hfff;  // white
        end else if (reg_we) begin
            case (reg_addr)
                `REG_CTRL: begin
                    enable     <= reg_wdata.ctrl_view.enable;
                    cidx       <= reg_wdata.ctrl_view.cidx;
                    frame_wait <= reg_wdata.ctrl_view.frame_wait;
                end
                `REG_PAL0, `REG_PAL1, `REG_PAL2, `REG_PAL3: begin
                    palette[pal_sel] <= reg_wdata.pal_view.rgb;
                end
                default: ;  // unmapped address
            endcase
        end
    end

endmodule

/* cube_sequencer.sv */
// walks the nine cube edges and hands each one to the line drawer
// oe opens after frame_wait frames, giving a visible delay before the cube appears
`timescale 1ns/1ps
`include "cube_macros.svh"

module cube_sequencer (
    input  logic             clk_pix,
    input  logic             arst_n,
    input  logic             enable,
    input  logic             frame,
    input  logic [7:0]       frame_wait,
    input  logic             draw_done,
    output draw_pkg::line_t  coords,
    output logic             start,
    output logic             oe,
    output logic             cube_done
);
    import draw_pkg::*;

    localparam int IDW = $clog2(`EDGE_CNT);

    // front face, then the receding edges and the visible back edges
    localparam line_t EDGES [`EDGE_CNT] = '{
        '{ 65, 30, 115, 30}, '{115, 30, 115, 80}, '{115, 80,  65, 80},
        '{ 65, 80,  65, 30}, '{ 65, 80,  45, 60}, '{ 45, 60,  45, 10},
        '{ 45, 10,  65, 30}, '{ 45, 10,  95, 10}, '{ 95, 10, 115, 30}
    };

    typedef enum logic [1:0] {IDLE, INIT, DRAW, DONE} state_t;
    state_t state;

    logic [IDW-1:0] edge_id;
    logic [7:0]     wait_cnt;  // frames left before oe

    assign cube_done = (state == DONE);

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            edge_id  <= '0;
            start    <= 1'b0;
            oe       <= 1'b0;
            wait_cnt <= '0;
        end else begin
            start <= 1'b0;
            case (state)
                IDLE: begin
                    edge_id <= '0;
                    oe      <= 1'b0;
                    if (enable && frame) begin  // runs begin on a frame boundary
                        state    <= INIT;
                        wait_cnt <= frame_wait;
                        oe       <= (frame_wait == 8'd0);
                    end
                end
                INIT: begin
                    start <= 1'b1;
                    state <= DRAW;
                end
                DRAW: begin
                    if (draw_done) begin
                        if (edge_id == IDW'(`EDGE_CNT - 1)) begin
                            state <= DONE;
                        end else begin
                            edge_id <= edge_id + 1'b1;
                            state   <= INIT;
                        end
                    end
                end
                DONE: if (!enable) state <= IDLE;
                default: state <= IDLE;
            endcase
            if (state != IDLE && !oe && frame) begin
                wait_cnt <= wait_cnt - 1'b1;
                oe       <= (wait_cnt == 8'd1);  // last wait frame seen
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (state == INIT) coords <= EDGES[edge_id];
    end

endmodule

/* top_cube.sv */
// cube demo top level: timing, registers, sequencer, line drawer and framebuffer
// display outputs are registered and trail the counters by two cycles
`timescale 1ns/1ps
`include "cube_macros.svh"

module top_cube (
    input  logic                 clk_pix,
    input  logic                 arst_n,
    input  logic                 reg_we,
    input  logic [2:0]           reg_addr,
    input  draw_pkg::reg_word_t  reg_wdata,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 de,
    output video_pkg::rgb_t      rgb,
    output logic                 cube_done
);
    import video_pkg::*;
    import draw_pkg::*;

    coord_t            sx, sy, fbx, fby;
    sync_t             sync, sync_p1;
    logic              frame;
    logic              enable;
    logic [`CIDXW-1:0] cidx;
    logic [7:0]        frame_wait;
    rgb_t [3:0]        palette;
    rgb_t              fb_rgb;
    line_t             coords;
    logic              draw_start, draw_oe, drawing, draw_done;

    display_timings display_timings_inst (
        .clk_pix, .arst_n, .sx, .sy, .sync, .frame,
        .line()  // framebuffer works from sx/sy alone
    );

    cube_regs cube_regs_inst (
        .clk_pix, .arst_n, .reg_we, .reg_addr, .reg_wdata,
        .enable, .cidx, .frame_wait, .palette
    );

    cube_sequencer cube_sequencer_inst (
        .clk_pix, .arst_n, .enable, .frame, .frame_wait, .draw_done,
        .coords, .start(draw_start), .oe(draw_oe), .cube_done
    );

    draw_line draw_line_inst (
        .clk_pix, .arst_n, .start(draw_start), .oe(draw_oe), .coords,
        .x(fbx), .y(fby), .drawing, .done(draw_done)
    );

    framebuffer framebuffer_inst (
        .clk_pix, .arst_n,
        .we(drawing), .wx(fbx), .wy(fby), .wcidx(cidx),  // every drawn pixel
        .sx, .sy, .palette, .rgb(fb_rgb)
    );

    // sync delayed once to meet the palette output, then all registered out
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sync_p1 <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};
            hsync   <= 1'b1;
            vsync   <= 1'b1;
            de      <= 1'b0;
            rgb     <= '0;
        end else begin
            sync_p1 <= sync;
            hsync   <= sync_p1.hsync;
            vsync   <= sync_p1.vsync;
            de      <= sync_p1.de;
            rgb     <= fb_rgb;
        end
    end

endmodule

/* top_cube_props.sv */
// concurrent checks on the cube top level, attached to every top_cube with bind
// covers the start pulse, the drawing bounds and de against hsync
`timescale 1ns/1ps
`include "cube_macros.svh"

module top_cube_props (
    input logic              clk_pix,
    input logic              arst_n,
    input logic              draw_start,
    input logic              drawing,
    input video_pkg::coord_t fbx,
    input video_pkg::coord_t fby,
    input logic              hsync,
    input logic              de
);

    int fail_cnt = 0;  // failed assertions so far

    start_one_cycle: assert property (@(posedge clk_pix) disable iff (!arst_n)
        draw_start |=> !draw_start)
        else begin
            fail_cnt++;
            $error("line drawer start held for more than one cycle");
        end

    // every drawn pixel lands inside the 160x90 store
    draw_in_bounds: assert property (@(posedge clk_pix) disable iff (!arst_n)
        drawing |-> (fbx >= 0 && fbx < `FB_WIDTH && fby >= 0 && fby < `FB_HEIGHT))
        else begin
            fail_cnt++;
            $error("line drawer position outside the framebuffer");
        end

    no_de_in_hsync: assert property (@(posedge clk_pix) disable iff (!arst_n)
        !(de && !hsync))
        else begin
            fail_cnt++;
            $error("de high during the hsync pulse");
        end

endmodule

bind top_cube top_cube_props props_inst (
    .clk_pix, .arst_n, .draw_start, .drawing, .fbx, .fby, .hsync, .de
);

/* tb_top_cube.sv */
// testbench for the cube demo: clock, reset, host register writes and a timeout
// top_cube_checker follows the display outputs and compares them with reference models
`timescale 1ns/1ps
`include "cube_macros.svh"

module top_cube_checker (
    input  logic                 clk_pix,
    input  logic                 arst_n,
    input  logic                 reg_we,
    input  logic [2:0]           reg_addr,
    input  draw_pkg::reg_word_t  reg_wdata,
    input  logic                 hsync,
    input  logic                 vsync,
    input  logic                 de,
    input  video_pkg::rgb_t      rgb,
    input  logic                 cube_done,
    output int                   timing_errs,
    output int                   pixel_errs,
    output int                   run_errs
);
    import video_pkg::*;
    import draw_pkg::*;

    localparam int H_TOTAL    = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
    localparam int V_TOTAL    = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;
    localparam int FRAME_CLKS = H_TOTAL * V_TOTAL;
    localparam int SHOW_MAX   = 20;  // pixel mismatches printed

    bit                on_edge [`FB_WIDTH * `FB_HEIGHT];
    rgb_t              pal [4];
    logic              en_m, busy, done_seen, drawn;
    logic [`CIDXW-1:0] cidx_m, drawn_cidx;
    logic [7:0]        fw_m;
    longint            cyc, en_cyc;
    int                px, py, hs_low, hs_per, vs_low, vs_per, de_run, de_frame;
    logic              hs_q, vs_q, de_q, done_q, synced, hs_seen, vs_seen;
    rgb_t              exp_rgb;

    // Bresenham walk over all octants, marks every pixel of one edge
    task automatic plot_edge(input int x0, input int y0, input int x1, input int y1);
        int dx, dy, stx, sty, err, e2, x, y;
        bit fin;
        dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy  = (y1 > y0) ? y0 - y1 : y1 - y0;
        stx = (x0 < x1) ? 1 : -1;
        sty = (y0 < y1) ? 1 : -1;
        err = dx + dy;
        x   = x0;
        y   = y0;
        fin = 0;
        while (!fin) begin
            on_edge[y * `FB_WIDTH + x] = 1'b1;
            fin = (x == x1 && y == y1);
            e2  = 2 * err;
            if (e2 >= dy) begin
                err = err + dy;
                x   = x + stx;
            end
            if (e2 <= dx) begin
                err = err + dx;
                y   = y + sty;
            end
        end
    endtask

    // letterbox map and scale by 4 back into the framebuffer grid
    function automatic rgb_t expected_pixel(input int x, input int y);
        int fx, fy;
        if (y < `LB_TOP || y >= `LB_BOTTOM) return '0;
        fx = x / `FB_SCALE;
        fy = (y - `LB_TOP) / `FB_SCALE;
        if (drawn && on_edge[fy * `FB_WIDTH + fx]) return pal[drawn_cidx];
        return pal[0];
    endfunction

    initial begin
        timing_errs = 0;
        pixel_errs  = 0;
        run_errs    = 0;
        {busy, done_seen, drawn, synced, hs_seen, vs_seen} = '0;
        {hs_q, vs_q, de_q, done_q} = 4'b1100;
        {cyc, en_cyc, px, py, hs_low, hs_per, vs_low, vs_per, de_run, de_frame} = '0;
        drawn_cidx = '0;
        // cube geometry: front face, receding edges, back edges
        plot_edge(65, 30, 115, 30);
        plot_edge(115, 30, 115, 80);
        plot_edge(115, 80, 65, 80);
        plot_edge(65, 80, 65, 30);
        plot_edge(65, 80, 45, 60);
        plot_edge(45, 60, 45, 10);
        plot_edge(45, 10, 65, 30);
        plot_edge(45, 10, 95, 10);
        plot_edge(95, 10, 115, 30);
    end

    // register map model, follows the host writes
    always @(posedge clk_pix) begin
        cyc = cyc + 1;
        if (!arst_n) begin
            pal    = '{12'h000, 12'hf00, 12'h0f0, 12'hfff};
            en_m   = 1'b0;
            cidx_m = '0;
            fw_m   = '0;
        end else if (reg_we) begin
            case (reg_addr)
                `REG_CTRL: begin
                    if (reg_wdata.ctrl_view.enable && !en_m) begin  // new run
                        busy   = 1'b1;
                        en_cyc = cyc;
                    end
                    en_m   = reg_wdata.ctrl_view.enable;
                    cidx_m = reg_wdata.ctrl_view.cidx;
                    fw_m   = reg_wdata.ctrl_view.frame_wait;
                end
                `REG_PAL0, `REG_PAL1, `REG_PAL2, `REG_PAL3: begin
                    pal[reg_addr - `REG_PAL0] = reg_wdata.pal_view.rgb;
                end
                default: ;
            endcase
        end
    end

    always @(negedge clk_pix) begin
        if (!arst_n) begin
            if (!hsync || !vsync || de || cube_done) begin
                run_errs++;
                $display("Fail %0t: outputs not idle while in reset", $time);
            end
        end else begin
            hs_per++;
            if (!hsync && hs_q) begin
                if (hs_seen && hs_per != H_TOTAL) begin
                    timing_errs++;
                    $display("Fail %0t: line period %0d clocks, expected %0d",
                             $time, hs_per, H_TOTAL);
                end
                hs_seen = 1'b1;
                hs_per  = 0;
                hs_low  = 0;
            end
            if (!hsync) hs_low++;
            if (hsync && !hs_q && hs_seen && hs_low != `H_SYNC) begin
                timing_errs++;
                $display("Fail %0t: hsync low for %0d clocks", $time, hs_low);
            end

            if (de) begin
                de_run++;
                de_frame++;
            end
            if (!de && de_q) begin
                if (de_run != `H_ACTIVE) begin
                    timing_errs++;
                    $display("Fail %0t: de high for %0d clocks in a line", $time, de_run);
                end
                de_run = 0;
            end

            vs_per++;
            if (!vsync && vs_q) begin  // frame boundary as seen on the outputs
                if (vs_seen && vs_per != FRAME_CLKS) begin
                    timing_errs++;
                    $display("Fail %0t: frame period %0d clocks", $time, vs_per);
                end
                if (vs_seen && de_frame != `H_ACTIVE * `V_ACTIVE) begin
                    timing_errs++;
                    $display("Fail %0t: de high for %0d clocks in a frame", $time, de_frame);
                end
                vs_seen  = 1'b1;
                vs_per   = 0;
                vs_low   = 0;
                de_frame = 0;
                synced   = 1'b1;
                py       = 0;
                if (done_seen && !drawn) begin  // picture complete from here on
                    drawn      = 1'b1;
                    drawn_cidx = cidx_m;
                end
            end
            if (!vsync) vs_low++;
            if (vsync && !vs_q && vs_seen && vs_low != `V_SYNC * H_TOTAL) begin
                timing_errs++;
                $display("Fail %0t: vsync low for %0d clocks", $time, vs_low);
            end

            if (de && !de_q) px = 0;
            if (de && synced) begin
                exp_rgb = expected_pixel(px, py);
                // letterbox skipped while the cube is still being drawn
                if (!(busy && !drawn && py >= `LB_TOP && py < `LB_BOTTOM) &&
                    rgb != exp_rgb) begin
                    if (pixel_errs < SHOW_MAX) begin
                        $display("Fail %0t: pixel (%0d,%0d) is %h, expected %h",
                                 $time, px, py, rgb, exp_rgb);
                    end
                    pixel_errs++;
                end
            end
            if (de) px++;
            if (!de && de_q) py++;

            if (cube_done && !done_q) begin
                if (!busy) begin
                    run_errs++;
                    $display("Fail %0t: cube_done rose without a run", $time);
                end else if (cyc - en_cyc < longint'(fw_m) * FRAME_CLKS) begin
                    run_errs++;
                    $display("Fail %0t: cube_done %0d cycles after enable, frame_wait %0d",
                             $time, cyc - en_cyc, fw_m);
                end
                done_seen = 1'b1;
            end
        end
        hs_q   = hsync;
        vs_q   = vsync;
        de_q   = de;
        done_q = cube_done;
    end

endmodule

module tb_top_cube;
    import video_pkg::*;
    import draw_pkg::*;

    localparam int     FRAME_CLKS = 800 * 525;
    localparam int     RUN_FRAMES = 10;  // frames the sequence below takes
    localparam longint LIMIT      = longint'(RUN_FRAMES + 2) * FRAME_CLKS;

    logic       clk_pix, arst_n, reg_we;
    logic [2:0] reg_addr;
    reg_word_t  reg_wdata;
    logic       hsync, vsync, de, cube_done;
    rgb_t       rgb;
    int         timing_errs, pixel_errs, run_errs;
    longint     cycles = 0;

    top_cube UUT (
        .clk_pix, .arst_n, .reg_we, .reg_addr, .reg_wdata,
        .hsync, .vsync, .de, .rgb, .cube_done
    );

    top_cube_checker checker_inst (
        .clk_pix, .arst_n, .reg_we, .reg_addr, .reg_wdata,
        .hsync, .vsync, .de, .rgb, .cube_done,
        .timing_errs, .pixel_errs, .run_errs
    );

    always #50 clk_pix = ~clk_pix;  // 10 MHz

    always @(posedge clk_pix) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: the run did not finish within %0d clock cycles", LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic write_reg(input logic [2:0] addr, input reg_word_t data);
        @(negedge clk_pix);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk_pix);
        reg_we    = 1'b0;
    endtask

    task automatic write_ctrl(input logic en, input logic [1:0] cidx, input logic [7:0] fw);
        reg_word_t w;
        w                      = '0;
        w.ctrl_view.enable     = en;
        w.ctrl_view.cidx       = cidx;
        w.ctrl_view.frame_wait = fw;
        write_reg(`REG_CTRL, w);
    endtask

    task automatic wait_vsync_fall();
        @(negedge clk_pix);
        while (!vsync) @(negedge clk_pix);
        while (vsync) @(negedge clk_pix);
    endtask

    initial begin
        clk_pix   = 1'b0;
        arst_n    = 1'b0;
        reg_we    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        repeat (3) @(negedge clk_pix);
        arst_n = 1'b1;
        wait_vsync_fall();
        wait_vsync_fall();                       // one blank frame checked
        write_reg(`REG_PAL0, 16'h0123);          // new background, inside vblank
        wait_vsync_fall();
        write_ctrl(1'b1, 2'd3, 8'd0);
        while (!cube_done) @(negedge clk_pix);
        wait_vsync_fall();
        wait_vsync_fall();                       // full picture checked
        write_ctrl(1'b0, 2'd3, 8'd0);
        while (cube_done) @(negedge clk_pix);
        write_ctrl(1'b1, 2'd3, 8'd2);            // second run, two frames late
        while (!cube_done) @(negedge clk_pix);
        wait_vsync_fall();
        wait_vsync_fall();
        $display("errors: timing %0d, pixel %0d, run %0d, assertion %0d",
                 timing_errs, pixel_errs, run_errs, UUT.props_inst.fail_cnt);
        if (timing_errs + pixel_errs + run_errs + UUT.props_inst.fail_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+.
video_pkg.sv
draw_pkg.sv
display_timings.sv
draw_line.sv
framebuffer.sv
cube_regs.sv
cube_sequencer.sv
top_cube.sv
top_cube_props.sv
tb_top_cube.sv

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top_cube -f all.f \
    -o sim_cube > build.log 2>&1 \
    && ./obj_dir/sim_cube > sim.log 2>&1 \
    || { echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
grep -q "TEST PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
